// File: sim.f
logic/fir_pkg.sv
logic/fir_coef_ram.sv
logic/fir_delay_line.sv
logic/fir_mac.sv
logic/fir_sequencer.sv
logic/fir_filter_top.sv
verif/fir_tb.sv

// File: Makefile
# Verilator build and run for the FIR filter testbench

VERILATOR ?= verilator
TOP       ?= fir_tb
FLAGS     ?= --binary --timing -Wno-fatal -j 0
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source is newer than the binary
$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

# status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;

  import fir_pkg::*;

  localparam int CLK_NS        = 20;
  localparam int MAX_STALL     = 8;                       // longest out_ready hold-off
  localparam int TOTAL_SAMPLES = 1 + 31 + 60 + 20 + 40;  // all five tests
  localparam int WATCHDOG_NS   =
    TOTAL_SAMPLES * (NUM_TAPS + 3 + MAX_STALL + 4) * CLK_NS + 40000;

  logic                     clk;
  logic                     reset_n;
  logic                     in_valid;
  logic                     in_ready;
  logic signed [DATA_W-1:0] in_data;
  logic                     out_valid;
  logic                     out_ready;
  logic signed [OUT_W-1:0]  out_data;
  coef_wr_t                 coef_wr;

  integer seed = 32'h10d3;

  // model state, k = 0 is the newest sample
  logic signed [COEF_W-1:0] coef_tb [NUM_TAPS];
  logic signed [DATA_W-1:0] hist_tb [NUM_TAPS];
  logic signed [OUT_W-1:0]  exp_q [$];              // expected results in order

  string cur_test;
  int    err_cnt    = 0;
  int    pass_cnt   = 0;
  int    sent_cnt   = 0;
  int    got_cnt    = 0;
  int    test_err0  = 0;
  int    cyc        = 0;                             // rising edges so far
  int    accept_cyc = 0;                             // edge of the last acceptance
  bit    bp_en      = 1'b0;                          // random out_ready stalls

  fir_filter_top dut_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .coef_wr   (coef_wr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // sum of coef[k] * hist[k] in 44 bits, then >>> 15 into 32 bits
  function automatic logic signed [OUT_W-1:0] expected_output();
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] h;
    logic signed [ACC_W-1:0] c;
    logic signed [ACC_W-1:0] sh;
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      h   = hist_tb[k];  // sign extends
      c   = coef_tb[k];
      acc = acc + h * c;
    end
    sh = acc >>> COEF_FRAC;
    return sh[OUT_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // drivers, all entered on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic load_random_coefs();
    for (int k = 0; k < NUM_TAPS; k++) begin
      coef_tb[k]    = $random(seed);
      coef_wr.valid = 1'b1;
      coef_wr.addr  = TAP_W'(k);
      coef_wr.data  = coef_tb[k];
      @(negedge clk);                               // write lands on the edge between
    end
    coef_wr.valid = 1'b0;
  endtask

  // use_given replaces the model value with one from the test itself
  task automatic send_sample(input logic signed [DATA_W-1:0] d, input bit use_given,
                             input logic signed [OUT_W-1:0] given);
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      hist_tb[k] = hist_tb[k-1];
    end
    hist_tb[0] = d;
    exp_q.push_back(use_given ? given : expected_output());
    sent_cnt++;
    in_valid = 1'b1;
    in_data  = d;
    while (!in_ready) @(negedge clk);               // in_ready settled since last rise
    accept_cyc = cyc + 1;                           // transfer on the coming edge
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || out_valid) @(negedge clk);
    @(negedge clk);                                 // sequencer back in idle
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    drain();
    if (got_cnt != sent_cnt) begin
      err_cnt++;
      $display("%s: %0d results received for %0d samples sent", cur_test, got_cnt, sent_cnt);
    end
    $display("test %s finished with %0d errors", cur_test, err_cnt - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // output side, stalls and compare
  ////////////////////////////////////////////////////////////
  initial begin : compare
    logic signed [OUT_W-1:0] held;
    logic signed [OUT_W-1:0] want;
    bit                      waiting;
    int                      stall_left;
    out_ready  = 1'b1;
    waiting    = 1'b0;
    stall_left = 0;
    forever begin
      @(negedge clk);
      if (reset_n && out_valid) begin
        if (!waiting) begin                         // fresh result
          waiting    = 1'b1;
          held       = out_data;
          stall_left = bp_en ? $unsigned($random(seed)) % (MAX_STALL + 1) : 0;
          if (cyc - accept_cyc != NUM_TAPS + 3) begin
            err_cnt++;
            $display("Mismatch %s latency: expected %0d, actual %0d",
                     cur_test, NUM_TAPS + 3, cyc - accept_cyc);
          end
        end
        if (in_ready) begin
          err_cnt++;
          $display("%s: in_ready is high while a result is pending", cur_test);
        end
        if (out_data !== held) begin
          err_cnt++;
          $display("%s: out_data changed while waiting for out_ready", cur_test);
        end
        if (stall_left > 0) begin
          out_ready = 1'b0;
          stall_left--;
        end else begin
          out_ready = 1'b1;                         // taken on the next rise
          waiting   = 1'b0;
          got_cnt++;
          if (exp_q.size() == 0) begin
            err_cnt++;
            $display("%s: a result arrived with no sample pending", cur_test);
          end else begin
            want = exp_q.pop_front();
            if (out_data !== want) begin
              err_cnt++;
              $display("Mismatch %s: expected %0d, actual %0d", cur_test, want, out_data);
            end else begin
              pass_cnt++;
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic signed [DATA_W-1:0] d;
    logic signed [OUT_W-1:0]  imp;
    reset_n  = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    coef_wr  = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      hist_tb[k] = '0;                              // matches the cleared delay line
    end
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    start_test("reset_state");
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
      err_cnt++;
      $display("%s: after reset in_ready is not high or out_valid is not low", cur_test);
    end
    load_random_coefs();
    send_sample($random(seed), 1'b0, '0);          // only tap 0 sees a nonzero sample
    end_test();

    start_test("impulse");
    repeat (NUM_TAPS - 1) send_sample('0, 1'b0, '0); // flush the earlier sample
    for (int k = 0; k < NUM_TAPS; k++) begin
      d   = (k == 0) ? 24'sd32768 : 24'sd0;
      imp = coef_tb[k];                             // 1.0 in Q15 times coef
      send_sample(d, 1'b1, imp);
    end
    end_test();

    start_test("random_stream");
    repeat (60) begin
      d = $random(seed);
      send_sample(d, 1'b0, '0);
    end
    end_test();

    start_test("coef_reload");
    load_random_coefs();                            // idle here, history carries on
    repeat (20) begin
      d = $random(seed);
      send_sample(d, 1'b0, '0);
    end
    end_test();

    start_test("back_pressure");
    bp_en = 1'b1;
    repeat (40) begin
      d = $random(seed);
      send_sample(d, 1'b0, '0);
    end
    end_test();
    bp_en = 1'b0;

    $display("results checked %0d, passed %0d, errors %0d", got_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: logic/fir_filter_top.sv
`timescale 1ns/1ps

module fir_filter_top (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic signed [fir_pkg::DATA_W-1:0] in_data,
  output logic                              out_valid,
  input  logic                              out_ready,
  output logic signed [fir_pkg::OUT_W-1:0]  out_data,
  input  fir_pkg::coef_wr_t                 coef_wr
);

  import fir_pkg::*;

  logic                     shift_en;
  logic [TAP_W-1:0]         tap_addr;  // shared by history and coefs
  tap_ctl_t                 issue;
  logic signed [DATA_W-1:0] tap_data;
  logic signed [COEF_W-1:0] coef_data;
  logic                     done;

  ////////////////////////////////////////////////////////////
  // tap engine
  ////////////////////////////////////////////////////////////
  fir_sequencer u_seq (
    .clk      (clk),
    .reset_n  (reset_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .done     (done),
    .shift_en (shift_en),
    .tap_addr (tap_addr),
    .issue    (issue)
  );

  fir_delay_line u_dly (
    .clk      (clk),
    .reset_n  (reset_n),
    .shift_en (shift_en),
    .in_data  (in_data),
    .tap_addr (tap_addr),
    .tap_data (tap_data)
  );

  fir_coef_ram u_coef (
    .clk       (clk),
    .coef_wr   (coef_wr),
    .tap_addr  (tap_addr),
    .coef_data (coef_data)
  );

  // multiply, accumulate, hold result
  fir_mac u_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .issue     (issue),
    .tap_data  (tap_data),
    .coef_data (coef_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .done      (done)
  );

endmodule

// File: logic/fir_sequencer.sv
`timescale 1ns/1ps

module fir_sequencer (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic                      done,
  output logic                      shift_en,
  output logic [fir_pkg::TAP_W-1:0] tap_addr,
  output fir_pkg::tap_ctl_t         issue
);

  import fir_pkg::*;

  logic [ST_W-1:0]  state;
  logic [TAP_W-1:0] tap_cnt; // next tap to issue
  logic             accept;

  ////////////////////////////////////////////////////////////
  // input handshake
  ////////////////////////////////////////////////////////////

  // ready while idle, or as soon as the mac reports the transfer
  assign in_ready = (state == ST_IDLE) || ((state == ST_WAIT) && done);
  assign accept   = in_valid && in_ready;
  assign shift_en = accept; // delay line shifts on the accept edge

  ////////////////////////////////////////////////////////////
  // controller and tap counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state    <= ST_IDLE;
      tap_cnt  <= '0;
      tap_addr <= '0;
      issue    <= '0;
    end else begin
      issue <= '0; // only RUN issues
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state   <= ST_RUN;
            tap_cnt <= '0;
          end
        end
        ST_RUN: begin
          tap_addr    <= tap_cnt;                // read goes out this edge
          issue.valid <= 1'b1;
          issue.first <= (tap_cnt == '0);        // newest sample
          issue.last  <= (tap_cnt == LAST_TAP);  // oldest sample
          tap_cnt     <= tap_cnt + 1'b1;
          if (tap_cnt == LAST_TAP) begin
            state <= ST_WAIT; // 16 issues done
          end
        end
        ST_WAIT: begin
          if (accept) begin            // back to back, skip idle
            state   <= ST_RUN;
            tap_cnt <= '0;
          end else if (done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: logic/fir_mac.sv
`timescale 1ns/1ps

module fir_mac (
  input  logic                              clk,
  input  logic                              reset_n,
  input  fir_pkg::tap_ctl_t                 issue,
  input  logic signed [fir_pkg::DATA_W-1:0] tap_data,
  input  logic signed [fir_pkg::COEF_W-1:0] coef_data,
  output logic                              out_valid,
  input  logic                              out_ready,
  output logic signed [fir_pkg::OUT_W-1:0]  out_data,
  output logic                              done
);

  import fir_pkg::*;

  tap_ctl_t                 ctl_op;    // issue aligned with operands
  tap_ctl_t                 ctl_prod;  // aligned with prod
  logic signed [PROD_W-1:0] prod;
  logic signed [ACC_W-1:0]  prod_ext;
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  acc_next;
  logic signed [ACC_W-1:0]  acc_shift;
  logic                     xfer;      // output handshake

  ////////////////////////////////////////////////////////////
  // control pipe
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ctl_op   <= '0;
      ctl_prod <= '0;
    end else begin
      ctl_op   <= issue;  // operands come back one cycle after issue
      ctl_prod <= ctl_op; // follows the product register
    end
  end

  ////////////////////////////////////////////////////////////
  // multiply
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ctl_op.valid) begin
      prod <= tap_data * coef_data; // 24x16 signed, full 40 bits
    end
  end

  // guard bits
  assign prod_ext = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (ctl_prod.first) acc_next = prod_ext;       // tap 0 restarts the sum
    else                acc_next = acc + prod_ext;
  end

  assign acc_shift = acc_next >>> COEF_FRAC; // arithmetic, sign kept

  always_ff @(posedge clk) begin
    if (ctl_prod.valid) begin
      acc <= acc_next;
    end
    if (ctl_prod.valid && ctl_prod.last) begin
      out_data <= acc_shift[OUT_W-1:0]; // upper bits are sign copies
    end
  end

  ////////////////////////////////////////////////////////////
  // output handshake
  ////////////////////////////////////////////////////////////
  assign xfer = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (ctl_prod.valid && ctl_prod.last) out_valid <= 1'b1;
      else if (xfer)                       out_valid <= 1'b0;
      done <= xfer; // one pulse, releases the sequencer
    end
  end

endmodule

// File: logic/fir_delay_line.sv
`timescale 1ns/1ps

module fir_delay_line (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              shift_en,
  input  logic signed [fir_pkg::DATA_W-1:0] in_data,
  input  logic [fir_pkg::TAP_W-1:0]         tap_addr,
  output logic signed [fir_pkg::DATA_W-1:0] tap_data
);

  import fir_pkg::*;

  // hist[0] newest, hist[NUM_TAPS-1] oldest
  logic signed [DATA_W-1:0] hist [NUM_TAPS];

  ////////////////////////////////////////////////////////////
  // sample history shift register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        hist[i] <= '0; // zero history, first result sees one sample
      end
    end else if (shift_en) begin
      hist[0] <= in_data; // accepted sample enters at the front
      for (int i = 1; i < NUM_TAPS; i++) begin
        hist[i] <= hist[i-1]; // everything ages one place
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tap select
  ////////////////////////////////////////////////////////////

  // registered mux, 1 cycle read latency
  // walks the whole history so synthesis sees a plain mux tree
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_TAPS; i++) begin
      if (tap_addr == TAP_W'(i)) begin
        tap_data <= hist[i];
      end
    end
  end

  // shift and read never overlap: the shift is on the
  // accept edge, the first read is the edge after

endmodule

// File: logic/fir_coef_ram.sv
`timescale 1ns/1ps

module fir_coef_ram (
  input  logic                             clk,
  input  fir_pkg::coef_wr_t                coef_wr,
  input  logic [fir_pkg::TAP_W-1:0]        tap_addr,
  output logic signed [fir_pkg::COEF_W-1:0] coef_data
);

  import fir_pkg::*;

  // coefficient table, contents undefined until written
  logic signed [COEF_W-1:0] mem [NUM_TAPS];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (coef_wr.valid) begin
      mem[coef_wr.addr] <= coef_wr.data; // lands on this edge
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // one cycle after tap_addr, lines up with the delay line mux
  always_ff @(posedge clk) begin
    coef_data <= mem[tap_addr];
  end

  // writes only happen while idle, so the read
  // never races a write to the same entry in practice

endmodule

// File: logic/fir_pkg.sv
package fir_pkg;

  ////////////////////////////////////////////////////////////
  // filter geometry
  ////////////////////////////////////////////////////////////
  localparam int NUM_TAPS  = 16;             // taps walked per sample
  localparam int TAP_W     = 4;              // tap index width
  localparam int DATA_W    = 24;             // audio sample, signed
  localparam int COEF_W    = 16;             // signed Q1.15
  localparam int PROD_W    = DATA_W + COEF_W; // full product, 40 bits
  localparam int ACC_W     = PROD_W + 4;     // 4 guard bits covers 16 taps
  localparam int OUT_W     = 32;             // result word
  localparam int COEF_FRAC = 15;             // drop Q15 fraction at output

  // index of the final tap, used for the last tag
  localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(NUM_TAPS - 1);

  ////////////////////////////////////////////////////////////
  // sequencer state codes
  ////////////////////////////////////////////////////////////
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE = 2'd0; // ready for a sample
  localparam logic [ST_W-1:0] ST_RUN  = 2'd1; // stepping taps
  localparam logic [ST_W-1:0] ST_WAIT = 2'd2; // result pending downstream

  ////////////////////////////////////////////////////////////
  // shared bundles
  ////////////////////////////////////////////////////////////

  // coefficient write, no handshake
  typedef struct packed {
    logic                     valid;
    logic [TAP_W-1:0]         addr;
    logic signed [COEF_W-1:0] data;
  } coef_wr_t;

  // one tap operation flowing through the mac pipe
  typedef struct packed {
    logic valid;
    logic first; // load accumulator
    logic last;  // write output register
  } tap_ctl_t;

endpackage
